/* sources.f */
+incdir+.
overlay_pkg.sv
glyph_rom.sv
overlay_layout.sv
overlay_char_select.sv
overlay_mixer.sv
debug_overlay.sv
tb_debug_overlay.sv

/* Makefile */
# Verilator build and run of the debug overlay testbench

.PHONY: all lint clean

all: obj_dir/Vtb_debug_overlay
	obj_dir/Vtb_debug_overlay | tee sim.log
	grep -q "Done: no errors" sim.log

obj_dir/Vtb_debug_overlay: sources.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -f sources.f --top-module tb_debug_overlay -Mdir obj_dir

lint:
	verilator --lint-only --timing -f sources.f --top-module debug_overlay

clean:
	rm -rf obj_dir sim.log

/* tb_overlay_model.svh */
`ifndef TB_OVERLAY_MODEL_SVH
`define TB_OVERLAY_MODEL_SVH

// Reference font for 0-9 and A-F
// Each glyph packs eight rows with the top row in the top byte
// Bit 0 of a row is the leftmost pixel
function automatic logic [63:0] ref_glyph(input int g);
    case (g)
        0:  return 64'h1C22_322A_2622_1C00;
        1:  return 64'h080C_0808_0808_1C00;
        2:  return 64'h1C22_2018_0402_3E00;
        3:  return 64'h3E20_1018_2022_1C00;
        4:  return 64'h1018_1412_3E10_1000;
        5:  return 64'h3E02_1E20_2022_1C00;
        6:  return 64'h3804_021E_2222_1C00;
        7:  return 64'h3E20_1008_0404_0400;
        8:  return 64'h1C22_221C_2222_1C00;
        9:  return 64'h1C22_223C_2010_0E00;
        10: return 64'h0814_2222_3E22_2200;
        11: return 64'h1E22_221E_2222_1E00;
        12: return 64'h1C22_0202_0222_1C00;
        13: return 64'h1E22_2222_2222_1E00;
        14: return 64'h3E02_021E_0202_3E00;
        15: return 64'h3E02_021E_0202_0200;
        default: return 64'h0;
    endcase
endfunction

// Glyph number of an ASCII character, -1 when the font lacks it
function automatic int glyph_of(input logic [7:0] ch);
    if (ch >= 8'h30 && ch <= 8'h39) begin
        return int'(ch) - 48;
    end
    if (ch >= 8'h41 && ch <= 8'h46) begin
        return int'(ch) - 55;
    end
    return -1;
endfunction

function automatic bit font_pixel(input int g, input int row, input int col);
    logic [63:0] rows;
    rows = ref_glyph(g);
    return rows[8*(7-row) + col];
endfunction

// Expected output colour of one pixel, straight from the band layout table
function automatic overlay_pkg::rgb_t expected_rgb(input int x, input int y,
        input overlay_pkg::rgb_t rgb_in, input overlay_pkg::debug_regs_t regs);
    int         rel_x;
    int         row;
    int         idx;
    int         g;
    logic [7:0] val;
    bit         lit;
    rel_x = x - `OVL_X_OFFSET;
    row   = y - `OVL_Y_OFFSET;
    lit   = 1'b0;
    if (rel_x < 0 || rel_x > 351 || row < 0 || row > 7) begin
        return rgb_in;
    end
    // Version cells, solid when the character has no glyph
    if (rel_x < 112) begin
        g   = glyph_of(VERSION_TEXT[8*(13-rel_x/8) +: 8]);
        lit = (g < 0) ? 1'b1 : font_pixel(g, row, rel_x % 8);
    end
    // Hex digits, high nibble first
    for (int f = 0; f < 4; f++) begin
        if (rel_x >= 120 + 24*f && rel_x < 136 + 24*f) begin
            val = regs.hex[f];
            idx = (rel_x - 120 - 24*f) / 8;
            lit = font_pixel((idx == 0) ? int'(val[7:4]) : int'(val[3:0]), row, rel_x % 8);
        end
    end
    // Binary digits, MSB on the left
    for (int f = 0; f < 2; f++) begin
        if (rel_x >= 216 + 72*f && rel_x < 280 + 72*f) begin
            val = regs.bits[f];
            idx = (rel_x - 216 - 72*f) / 8;
            lit = font_pixel(int'(val[7-idx]), row, rel_x % 8);
        end
    end
    return lit ? overlay_pkg::rgb_t'(24'hFFFFFF) : rgb_in;
endfunction

task automatic check_equal(input string test_name, input logic [23:0] expected,
        input logic [23:0] actual);
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: expected %06h, actual %06h", test_name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "Output colour mismatch");
    end
endtask

`endif

/* tb_debug_overlay.sv */
`timescale 1ns/1ps
`include "overlay_config.svh"

module tb_debug_overlay;

    localparam logic [8*`OVL_VERSION_CHARS-1:0] VERSION_TEXT = "V1.0 AB-12 cd9";

    // Drives per test for sizing the watchdog
    localparam int TOTAL_CYCLES = 72 + 896 + 1412 + 2180 + 1440 + 3002 + 2;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 500) * 100;

    logic                     clk_i;
    logic                     rst_i;
    overlay_pkg::screen_pos_t pos_i;
    overlay_pkg::rgb_t        rgb_i;
    overlay_pkg::debug_regs_t regs_i;
    overlay_pkg::rgb_t        rgb_o;
    int                       error_count = 0;

    // Expected colours in flight stay two drives deep once running
    overlay_pkg::rgb_t exp_q[$];
    string             name_q[$];

    `include "tb_overlay_model.svh"

    debug_overlay #(
        .VERSION (VERSION_TEXT)
    ) i_dut (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .pos_i  (pos_i),
        .rgb_i  (rgb_i),
        .regs_i (regs_i),
        .rgb_o  (rgb_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic overlay_pkg::rgb_t random_rgb();
        logic [31:0] r;
        r = $urandom;
        return r[23:0];
    endfunction

    function automatic overlay_pkg::debug_regs_t random_regs();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[47:0];
    endfunction

    // One pixel per cycle
    // The output now belongs to the pixel two drives back
    task automatic drive_pixel(input string test_name, input int x, input int y,
            input overlay_pkg::rgb_t rgb, input logic rst);
        @(posedge clk_i);
        #1;
        if (exp_q.size() >= 2) begin
            check_equal(name_q.pop_front(), exp_q.pop_front(), rgb_o);
        end
        rst_i   = rst;
        pos_i.x = overlay_pkg::coord_t'(x);
        pos_i.y = overlay_pkg::coord_t'(y);
        rgb_i   = rgb;
        // A pixel that meets reset in either stage comes out black
        // The pixel one drive ahead sits in stage 2 when this reset is sampled
        if (rst && exp_q.size() > 0) begin
            exp_q[exp_q.size()-1] = overlay_pkg::rgb_t'(24'h0);
        end
        exp_q.push_back(rst ? overlay_pkg::rgb_t'(24'h0) : expected_rgb(x, y, rgb, regs_i));
        name_q.push_back(test_name);
    endtask

    // Two off-band pixels go first so no band pixel still waits for stage 2
    task automatic reload_regs(input string test_name);
        drive_pixel(test_name, 0, 0, random_rgb(), 1'b0);
        drive_pixel(test_name, 0, 0, random_rgb(), 1'b0);
        regs_i = random_regs();
    endtask

    task automatic test_reset_latency();
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < 4; i++) begin
                drive_pixel("reset_latency", $urandom_range(0, 399), 28, random_rgb(), 1'b1);
            end
            for (int i = 0; i < 32; i++) begin
                drive_pixel("reset_latency", $urandom_range(0, 399), $urandom_range(20, 35),
                            random_rgb(), 1'b0);
            end
        end
    endtask

    task automatic test_version_scan();
        for (int y = 24; y < 32; y++) begin
            for (int x = 16; x < 128; x++) begin
                drive_pixel("version_scan", x, y, random_rgb(), 1'b0);
            end
        end
    endtask

    task automatic test_hex_fields();
        for (int n = 0; n < 2; n++) begin
            reload_regs("hex_fields");
            for (int y = 24; y < 32; y++) begin
                for (int x = 136; x < 224; x++) begin
                    drive_pixel("hex_fields", x, y, random_rgb(), 1'b0);
                end
            end
        end
    endtask

    task automatic test_bit_fields();
        for (int n = 0; n < 2; n++) begin
            reload_regs("bit_fields");
            for (int y = 24; y < 32; y++) begin
                for (int x = 232; x < 368; x++) begin
                    drive_pixel("bit_fields", x, y, random_rgb(), 1'b0);
                end
            end
        end
    endtask

    task automatic test_passthrough();
        int gaps[6] = '{112, 136, 160, 184, 208, 280};
        for (int y = 24; y < 32; y++) begin
            for (int g = 0; g < 6; g++) begin
                for (int c = 0; c < 8; c++) begin
                    drive_pixel("passthrough", 16 + gaps[g] + c, y, random_rgb(), 1'b0);
                end
            end
            // Left of the band and right of it
            for (int c = 0; c < 16; c++) begin
                drive_pixel("passthrough", c, y, random_rgb(), 1'b0);
                drive_pixel("passthrough", 368 + c, y, random_rgb(), 1'b0);
            end
        end
        // Rows just above and below the band
        for (int x = 0; x < 400; x++) begin
            drive_pixel("passthrough", x, 23, random_rgb(), 1'b0);
            drive_pixel("passthrough", x, 32, random_rgb(), 1'b0);
        end
    endtask

    task automatic test_random_stream();
        reload_regs("random_stream");
        for (int i = 0; i < 3000; i++) begin
            drive_pixel("random_stream", $urandom_range(0, 383), $urandom_range(22, 33),
                        random_rgb(), 1'b0);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Done: errors found");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        pos_i = '0;
        rgb_i = '0;
        void'($urandom(32'hf09b));
        regs_i = random_regs();
        test_reset_latency();
        test_version_scan();
        test_hex_fields();
        test_bit_fields();
        test_passthrough();
        test_random_stream();
        // Push the last real pixels out of the pipeline
        drive_pixel("drain", 0, 0, random_rgb(), 1'b0);
        drive_pixel("drain", 0, 0, random_rgb(), 1'b0);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* debug_overlay.sv */
`timescale 1ns/1ps
`include "overlay_config.svh"

module debug_overlay #(
    // Fourteen ASCII characters shown at the start of the band
    parameter logic [8*`OVL_VERSION_CHARS-1:0] VERSION = "00000000000000"
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  overlay_pkg::screen_pos_t pos_i,
    input  overlay_pkg::rgb_t        rgb_i,
    input  overlay_pkg::debug_regs_t regs_i,
    output overlay_pkg::rgb_t        rgb_o
);

    // Stage 1 outputs
    overlay_pkg::glyph_slot_t slot;
    overlay_pkg::rgb_t        rgb_d;

    // Combinational lookup between the stages
    logic [7:0] code;
    logic [7:0] font_bits;
    logic       font_hit;

    overlay_layout i_layout (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .pos_i  (pos_i),
        .rgb_i  (rgb_i),
        .slot_o (slot),
        .rgb_o  (rgb_d)
    );

    // Debug values are sampled here one edge after their position
    overlay_char_select #(
        .VERSION (VERSION)
    ) i_char_select (
        .slot_i (slot),
        .regs_i (regs_i),
        .code_o (code)
    );

    glyph_rom i_glyph_rom (
        .code_i (code),
        .row_i  (slot.row),
        .bits_o (font_bits),
        .hit_o  (font_hit)
    );

    overlay_mixer i_mixer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .slot_i      (slot),
        .rgb_i       (rgb_d),
        .font_bits_i (font_bits),
        .font_hit_i  (font_hit),
        .rgb_o       (rgb_o)
    );

endmodule

/* overlay_mixer.sv */
`timescale 1ns/1ps

module overlay_mixer (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  overlay_pkg::glyph_slot_t slot_i,
    input  overlay_pkg::rgb_t        rgb_i,
    input  logic [7:0]               font_bits_i,
    input  logic                     font_hit_i,
    output overlay_pkg::rgb_t        rgb_o
);

    // Text colour
    localparam overlay_pkg::rgb_t WHITE = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};

    logic lit;

    always_comb begin
        case (slot_i.kind)
            overlay_pkg::SLOT_VERSION: begin
                // A character without a glyph fills its whole cell
                lit = font_hit_i ? font_bits_i[slot_i.col] : 1'b1;
            end
            overlay_pkg::SLOT_HEX, overlay_pkg::SLOT_BITS: begin
                lit = font_hit_i & font_bits_i[slot_i.col];
            end
            default: begin
                // Gaps and off-band pixels keep the input colour
                lit = 1'b0;
            end
        endcase
    end

    // Stage 2 register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rgb_o <= '0;
        end else begin
            rgb_o <= lit ? WHITE : rgb_i;
        end
    end

    // Both pipeline stages clear on reset
    // so the output stays black for two edges after it
    a_reset_black: assert property (
        @(posedge clk_i)
        rst_i |=> (rgb_o == '0) ##1 (rgb_o == '0)
    );

endmodule

/* overlay_char_select.sv */
`timescale 1ns/1ps
`include "overlay_config.svh"

module overlay_char_select #(
    // Version text as a string literal with character 0 in the top byte
    parameter logic [8*`OVL_VERSION_CHARS-1:0] VERSION = "00000000000000"
) (
    input  overlay_pkg::glyph_slot_t slot_i,
    input  overlay_pkg::debug_regs_t regs_i,
    output logic [7:0]               code_o
);

    logic [3:0] ver_pos;
    logic [7:0] hex_byte;
    logic [3:0] nibble;
    logic [7:0] bit_byte;
    logic       bit_val;

    // Byte lane of the string holding the selected character
    assign ver_pos  = 4'(`OVL_VERSION_CHARS - 1) - slot_i.char_idx;

    // Hex digit 0 shows the high nibble
    assign hex_byte = regs_i.hex[slot_i.field];
    assign nibble   = slot_i.char_idx[0] ? hex_byte[3:0] : hex_byte[7:4];

    // Binary digit 0 shows bit 7
    // Only two binary fields exist so one field bit is enough
    assign bit_byte = regs_i.bits[slot_i.field[0]];
    assign bit_val  = bit_byte[3'd7 - slot_i.char_idx[2:0]];

    always_comb begin
        case (slot_i.kind)
            overlay_pkg::SLOT_VERSION: begin
                code_o = VERSION[{ver_pos, 3'b000} +: 8];
            end
            overlay_pkg::SLOT_HEX: begin
                // '0'..'9' start at 0x30 and 'A'..'F' at 0x41
                if (nibble < 4'hA) begin
                    code_o = 8'h30 + {4'h0, nibble};
                end else begin
                    code_o = 8'h37 + {4'h0, nibble};
                end
            end
            overlay_pkg::SLOT_BITS: begin
                code_o = bit_val ? 8'h31 : 8'h30;
            end
            default: begin
                // Space for gap and off-band pixels
                // the mixer leaves these unlit anyway
                code_o = 8'h20;
            end
        endcase
    end

endmodule

/* overlay_layout.sv */
`timescale 1ns/1ps
`include "overlay_config.svh"

module overlay_layout (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  overlay_pkg::screen_pos_t pos_i,
    input  overlay_pkg::rgb_t        rgb_i,
    output overlay_pkg::glyph_slot_t slot_o,
    output overlay_pkg::rgb_t        rgb_o
);

    // Field geometry in pixels from the left edge of the band
    localparam int CW         = `OVL_CHAR_W;
    localparam int VER_END    = `OVL_VERSION_CHARS * CW;
    // A hex field holds two digits and a binary field eight
    localparam int HEX_LEN    = 2 * CW;
    localparam int BITS_LEN   = 8 * CW;
    localparam int HEX_BASE   = VER_END + `OVL_GAP;
    localparam int HEX_PITCH  = HEX_LEN + `OVL_GAP;
    localparam int BITS_BASE  = HEX_BASE + `OVL_HEX_FIELDS * HEX_PITCH;
    localparam int BITS_PITCH = BITS_LEN + `OVL_GAP;
    // No trailing gap after the last binary field
    localparam int BAND_END   = BITS_BASE + `OVL_BIT_FIELDS * BITS_PITCH - `OVL_GAP;

    overlay_pkg::coord_t      rel_x;
    overlay_pkg::coord_t      rel_y;
    logic                     in_band;
    overlay_pkg::glyph_slot_t slot_d;

    assign rel_x = pos_i.x - overlay_pkg::coord_t'(`OVL_X_OFFSET);
    assign rel_y = pos_i.y - overlay_pkg::coord_t'(`OVL_Y_OFFSET);

    // Left and top edges are tested on the raw position
    // because the relative values wrap below the offsets
    assign in_band = (pos_i.x >= overlay_pkg::coord_t'(`OVL_X_OFFSET))
                  && (rel_x < overlay_pkg::coord_t'(BAND_END))
                  && (pos_i.y >= overlay_pkg::coord_t'(`OVL_Y_OFFSET))
                  && (rel_y < overlay_pkg::coord_t'(`OVL_CHAR_H));

    // Classify the pixel and find its offset inside the owning field
    always_comb begin
        overlay_pkg::coord_t off;

        off         = rel_x;
        slot_d      = '0;
        slot_d.kind = overlay_pkg::SLOT_NONE;

        if (in_band) begin
            // Band pixels not claimed by any field are gap
            slot_d.kind = overlay_pkg::SLOT_GAP;

            if (rel_x < overlay_pkg::coord_t'(VER_END)) begin
                slot_d.kind = overlay_pkg::SLOT_VERSION;
                off         = rel_x;
            end

            for (int f = 0; f < `OVL_HEX_FIELDS; f++) begin
                if ((rel_x >= overlay_pkg::coord_t'(HEX_BASE + f * HEX_PITCH))
                        && (rel_x < overlay_pkg::coord_t'(HEX_BASE + f * HEX_PITCH + HEX_LEN)))
                begin
                    slot_d.kind  = overlay_pkg::SLOT_HEX;
                    slot_d.field = 2'(f);
                    off          = rel_x - overlay_pkg::coord_t'(HEX_BASE + f * HEX_PITCH);
                end
            end

            for (int f = 0; f < `OVL_BIT_FIELDS; f++) begin
                if ((rel_x >= overlay_pkg::coord_t'(BITS_BASE + f * BITS_PITCH))
                        && (rel_x < overlay_pkg::coord_t'(BITS_BASE + f * BITS_PITCH + BITS_LEN)))
                begin
                    slot_d.kind  = overlay_pkg::SLOT_BITS;
                    slot_d.field = 2'(f);
                    off          = rel_x - overlay_pkg::coord_t'(BITS_BASE + f * BITS_PITCH);
                end
            end
        end

        // Glyphs are 8 pixels wide
        // so the low three offset bits give the column and the next four the character
        slot_d.char_idx = off[6:3];
        slot_d.col      = off[2:0];
        slot_d.row      = rel_y[2:0];
    end

    // Stage 1 register
    // The colour travels alongside the slot to stay aligned with it
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            slot_o <= '0;
            rgb_o  <= '0;
        end else begin
            slot_o <= slot_d;
            rgb_o  <= rgb_i;
        end
    end

    // Version slots never point past the last string character
    a_version_idx: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (slot_o.kind == overlay_pkg::SLOT_VERSION)
            |-> (slot_o.char_idx < 4'(`OVL_VERSION_CHARS))
    );

    // Binary slots select one of the eight bits of a byte
    a_bits_idx: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (slot_o.kind == overlay_pkg::SLOT_BITS) |-> (slot_o.char_idx < 4'd8)
    );

endmodule

/* glyph_rom.sv */
`timescale 1ns/1ps

module glyph_rom (
    input  logic [7:0] code_i,
    input  logic [2:0] row_i,
    output logic [7:0] bits_o,
    output logic       hit_o
);

    // Eight rows per glyph, top row first
    // Bit 0 of a row is the leftmost pixel
    localparam logic [7:0] FONT [0:127] = '{
        // 0
        8'h1C, 8'h22, 8'h32, 8'h2A, 8'h26, 8'h22, 8'h1C, 8'h00,
        // 1
        8'h08, 8'h0C, 8'h08, 8'h08, 8'h08, 8'h08, 8'h1C, 8'h00,
        // 2
        8'h1C, 8'h22, 8'h20, 8'h18, 8'h04, 8'h02, 8'h3E, 8'h00,
        // 3
        8'h3E, 8'h20, 8'h10, 8'h18, 8'h20, 8'h22, 8'h1C, 8'h00,
        // 4
        8'h10, 8'h18, 8'h14, 8'h12, 8'h3E, 8'h10, 8'h10, 8'h00,
        // 5
        8'h3E, 8'h02, 8'h1E, 8'h20, 8'h20, 8'h22, 8'h1C, 8'h00,
        // 6
        8'h38, 8'h04, 8'h02, 8'h1E, 8'h22, 8'h22, 8'h1C, 8'h00,
        // 7
        8'h3E, 8'h20, 8'h10, 8'h08, 8'h04, 8'h04, 8'h04, 8'h00,
        // 8
        8'h1C, 8'h22, 8'h22, 8'h1C, 8'h22, 8'h22, 8'h1C, 8'h00,
        // 9
        8'h1C, 8'h22, 8'h22, 8'h3C, 8'h20, 8'h10, 8'h0E, 8'h00,
        // A
        8'h08, 8'h14, 8'h22, 8'h22, 8'h3E, 8'h22, 8'h22, 8'h00,
        // B
        8'h1E, 8'h22, 8'h22, 8'h1E, 8'h22, 8'h22, 8'h1E, 8'h00,
        // C
        8'h1C, 8'h22, 8'h02, 8'h02, 8'h02, 8'h22, 8'h1C, 8'h00,
        // D
        8'h1E, 8'h22, 8'h22, 8'h22, 8'h22, 8'h22, 8'h1E, 8'h00,
        // E
        8'h3E, 8'h02, 8'h02, 8'h1E, 8'h02, 8'h02, 8'h3E, 8'h00,
        // F
        8'h3E, 8'h02, 8'h02, 8'h1E, 8'h02, 8'h02, 8'h02, 8'h00
    };

    logic       is_digit;
    logic       is_upper;
    logic [3:0] glyph;

    // Decimal digits are 0x30..0x39
    assign is_digit = (code_i >= 8'h30) && (code_i <= 8'h39);
    // Upper-case hex letters are 0x41..0x46
    assign is_upper = (code_i >= 8'h41) && (code_i <= 8'h46);
    assign hit_o    = is_digit | is_upper;

    // Letters follow the ten digits in the table
    // 'A' has low nibble 1 and lands on glyph 10
    assign glyph = is_upper ? (code_i[3:0] + 4'd9) : code_i[3:0];

    // Unknown codes read as an empty row
    assign bits_o = hit_o ? FONT[{glyph, row_i}] : 8'h00;

endmodule

/* overlay_pkg.sv */
`include "overlay_config.svh"

package overlay_pkg;

    // One screen coordinate
    typedef logic [`OVL_COORD_W-1:0] coord_t;

    // Pixel position as it arrives with each pixel
    typedef struct packed {
        coord_t x;
        coord_t y;
    } screen_pos_t;

    // 24-bit colour with red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Debug values on display
    // hex[n] feeds hex field n and bits[n] feeds binary field n
    typedef struct packed {
        logic [`OVL_HEX_FIELDS-1:0][7:0] hex;
        logic [`OVL_BIT_FIELDS-1:0][7:0] bits;
    } debug_regs_t;

    // What a pixel position falls on
    // SLOT_NONE must stay zero so a cleared slot reads as outside the band
    typedef enum logic [2:0] {
        SLOT_NONE    = 3'd0,
        SLOT_GAP     = 3'd1,
        SLOT_VERSION = 3'd2,
        SLOT_HEX     = 3'd3,
        SLOT_BITS    = 3'd4
    } slot_kind_e;

    // Result of the layout stage for one pixel
    typedef struct packed {
        slot_kind_e kind;
        logic [1:0] field;
        logic [3:0] char_idx;
        logic [2:0] col;
        logic [2:0] row;
    } glyph_slot_t;

endpackage

/* overlay_config.svh */
`ifndef OVERLAY_CONFIG_SVH
`define OVERLAY_CONFIG_SVH

// Glyph cell size in pixels
`define OVL_CHAR_W 8
`define OVL_CHAR_H 8

// Top left corner of the text band on screen
`define OVL_X_OFFSET 16
`define OVL_Y_OFFSET 24

// Blank pixels between two neighbouring fields
`define OVL_GAP 8

// Characters in the version string
`define OVL_VERSION_CHARS 14

// Number of two-digit hex fields and eight-digit binary fields
`define OVL_HEX_FIELDS 4
`define OVL_BIT_FIELDS 2

// Width of a screen coordinate
`define OVL_COORD_W 10

`endif
